/* stripe_pkg.sv */
// Stripe write front end shared widths, response codes and merge helper
`default_nettype none

package stripe_pkg;

  // Widest channel number supported
  localparam int CHAN_BITS_MAX = 4;

  // Byte address
  typedef logic [31:0] addr_t;
  // Byte length of a request or a sub-write, never zero
  typedef logic [15:0] len_t;
  // Write response code, higher is worse
  typedef logic [1:0] resp_t;
  // Channel number, only the low bits used
  typedef logic [CHAN_BITS_MAX-1:0] chan_t;

  // Response codes
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_EXOKAY = 2'd1;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // Worst of two response codes
  function automatic resp_t resp_worse(input resp_t a, input resp_t b);
    return (a > b) ? a : b;
  endfunction

endpackage

`default_nettype wire

/* stripe_fifo.sv */
// Synchronous first-word-fall-through FIFO with a fill count
`timescale 1ns/1ps
`default_nettype none

module stripe_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  logic [WIDTH-1:0] wr_data,
  output logic             rd_valid,
  input  logic             rd_ready,
  output logic [WIDTH-1:0] rd_data
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Storage, payload only
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // Full and empty straight from the count
  assign wr_ready = (count != CW'(DEPTH));
  assign rd_valid = (count != '0);
  // Head word always on the output
  assign rd_data  = mem[rd_ptr];
  assign do_wr    = wr_valid && wr_ready;
  assign do_rd    = rd_valid && rd_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Count tracks the net change
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* stripe_aw_split.sv */
// Write request splitter, cuts requests at stripe boundaries and logs piece order
`timescale 1ns/1ps
`default_nettype none

module stripe_aw_split
  import stripe_pkg::*;
#(
  parameter int N_CHAN     = 4,
  parameter int STRIPE_LOG = 8
) (
  input  logic  aclk,
  input  logic  aresetn,
  // Incoming write requests
  input  logic  s_req_valid,
  output logic  s_req_ready,
  input  addr_t s_req_addr,
  input  len_t  s_req_len,
  // Sub-writes to the channels
  output logic  m_aw_valid,
  input  logic  m_aw_ready,
  output chan_t m_aw_chan,
  output addr_t m_aw_addr,
  output len_t  m_aw_len,
  // Order record for the reorder block
  output logic  ord_valid,
  input  logic  ord_ready,
  output chan_t ord_chan,
  output logic  ord_last
);

  localparam int    CW           = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
  localparam addr_t STRIPE_BYTES = addr_t'(1) << STRIPE_LOG;

  typedef enum logic {IDLE, ISSUE} state_t;

  state_t state;
  // Current piece start and bytes still to issue
  addr_t  cur_addr;
  len_t   rem;
  addr_t  to_bound;
  len_t   piece_len;
  logic   piece_last;
  logic   aw_hs;

  // Bytes left up to the next stripe boundary
  assign to_bound   = STRIPE_BYTES - (cur_addr & (STRIPE_BYTES - 1'b1));
  // Piece stops at the boundary or at the request end
  assign piece_len  = (addr_t'(rem) <= to_bound) ? rem : len_t'(to_bound);
  assign piece_last = (rem == piece_len);

  assign s_req_ready = (state == IDLE);

  // Each side sees valid only when the other can take the piece,
  // so both handshakes land in the same cycle
  // ord_ready only drops after our own write, so m_aw_valid holds until taken
  assign m_aw_valid = (state == ISSUE) && ord_ready;
  assign ord_valid  = (state == ISSUE) && m_aw_ready;
  assign aw_hs      = (state == ISSUE) && m_aw_ready && ord_ready;

  // Stripe number modulo channel count
  assign m_aw_chan = chan_t'(cur_addr[STRIPE_LOG +: CW]);
  assign m_aw_addr = cur_addr;
  assign m_aw_len  = piece_len;
  assign ord_chan  = m_aw_chan;
  assign ord_last  = piece_last;

  // FSM
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (s_req_valid) state <= ISSUE;
        ISSUE:   if (aw_hs && piece_last) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address and remainder, loaded on accept, advanced per piece
  always_ff @(posedge aclk) begin
    if (s_req_valid && s_req_ready) begin
      cur_addr <= s_req_addr;
      rem      <= s_req_len;
    end else if (aw_hs) begin
      cur_addr <= cur_addr + addr_t'(piece_len);
      rem      <= rem - piece_len;
    end
  end

endmodule

`default_nettype wire

/* stripe_b_arbiter.sv */
// Round-robin arbiter joining the channel write responses onto one return bus
`timescale 1ns/1ps
`default_nettype none

module stripe_b_arbiter
  import stripe_pkg::*;
#(
  parameter int N_CHAN = 4
) (
  input  logic                aclk,
  input  logic                aresetn,
  // Per-channel response ports
  input  logic  [N_CHAN-1:0]  ch_b_valid,
  output logic  [N_CHAN-1:0]  ch_b_ready,
  input  resp_t [N_CHAN-1:0]  ch_b_resp,
  // Shared return bus
  output logic                rb_valid,
  input  logic                rb_ready,
  output chan_t               rb_chan,
  output resp_t               rb_resp
);

  localparam int CW = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

  // Highest priority channel this round
  logic [CW-1:0] ptr;
  logic [CW-1:0] win;
  logic          found;

  // First valid channel at or after the pointer
  always_comb begin
    win   = ptr;
    found = 1'b0;
    for (int k = 0; k < N_CHAN; k++) begin
      if (!found && ch_b_valid[CW'((int'(ptr) + k) % N_CHAN)]) begin
        win   = CW'((int'(ptr) + k) % N_CHAN);
        found = 1'b1;
      end
    end
  end

  assign rb_valid = found;
  assign rb_chan  = chan_t'(win);
  assign rb_resp  = ch_b_resp[win];

  // Ready back to the winner only
  always_comb begin
    ch_b_ready      = '0;
    ch_b_ready[win] = rb_ready && found;
  end

  // Pointer steps past the winner on each bus handshake
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ptr <= '0;
    end else if (found && rb_ready) begin
      ptr <= (win == CW'(N_CHAN - 1)) ? '0 : win + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* stripe_b_reorder.sv */
// Response reorder, queues pieces per channel and merges them per request in order
`timescale 1ns/1ps
`default_nettype none

module stripe_b_reorder
  import stripe_pkg::*;
#(
  parameter int N_CHAN    = 4,
  parameter int ORD_DEPTH = 16,
  parameter int RSP_DEPTH = 8
) (
  input  logic  aclk,
  input  logic  aresetn,
  // Shared return bus
  input  logic  rb_valid,
  output logic  rb_ready,
  input  chan_t rb_chan,
  input  resp_t rb_resp,
  // Piece order from the splitter
  input  logic  ord_valid,
  output logic  ord_ready,
  input  chan_t ord_chan,
  input  logic  ord_last,
  // Merged in-order responses
  output logic  m_b_valid,
  input  logic  m_b_ready,
  output resp_t m_b_resp
);

  localparam int CW = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
  localparam int OW = CHAN_BITS_MAX + 1;

  typedef enum logic {IDLE, MERGE} state_t;

  state_t                state;
  // Worst code folded so far, valid in MERGE only
  resp_t                 acc;
  logic                  ord_rd_valid;
  logic                  ord_rd_ready;
  logic  [OW-1:0]        ord_head;
  logic  [CW-1:0]        head_idx;
  logic                  head_last;
  logic  [CW-1:0]        rb_idx;
  logic  [N_CHAN-1:0]    q_wr_valid;
  logic  [N_CHAN-1:0]    q_wr_ready;
  logic  [N_CHAN-1:0]    q_rd_valid;
  logic  [N_CHAN-1:0]    q_rd_ready;
  resp_t [N_CHAN-1:0]    q_rd_data;
  logic                  piece_avail;
  logic                  pop;
  resp_t                 merged;

  // Order queue, entry is {last, chan}
  stripe_fifo #(.WIDTH(OW), .DEPTH(ORD_DEPTH)) i_ord_q (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_valid (ord_valid),
    .wr_ready (ord_ready),
    .wr_data  ({ord_last, ord_chan}),
    .rd_valid (ord_rd_valid),
    .rd_ready (ord_rd_ready),
    .rd_data  (ord_head)
  );

  assign head_idx  = ord_head[CW-1:0];
  assign head_last = ord_head[OW-1];

  // Steer the bus into the tagged channel queue
  assign rb_idx   = rb_chan[CW-1:0];
  assign rb_ready = q_wr_ready[rb_idx];

  for (genvar i = 0; i < N_CHAN; i++) begin : g_rsp_q
    assign q_wr_valid[i] = rb_valid && (rb_idx == CW'(i));
    assign q_rd_ready[i] = pop && (head_idx == CW'(i));

    stripe_fifo #(.WIDTH($bits(resp_t)), .DEPTH(RSP_DEPTH)) i_rsp_q (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .wr_valid (q_wr_valid[i]),
      .wr_ready (q_wr_ready[i]),
      .wr_data  (rb_resp),
      .rd_valid (q_rd_valid[i]),
      .rd_ready (q_rd_ready[i]),
      .rd_data  (q_rd_data[i])
    );
  end

  // Head entry has its piece waiting
  assign piece_avail = ord_rd_valid && q_rd_valid[head_idx];
  // Fresh request starts from OKAY
  assign merged = resp_worse((state == MERGE) ? acc : RESP_OKAY, q_rd_data[head_idx]);

  // Last piece goes out, earlier ones fold silently
  assign m_b_valid    = piece_avail && head_last;
  assign m_b_resp     = merged;
  assign pop          = piece_avail && (!head_last || m_b_ready);
  assign ord_rd_ready = pop;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else if (pop) begin
      state <= head_last ? IDLE : MERGE;
    end
  end

  always_ff @(posedge aclk) begin
    if (pop && !head_last) begin
      acc <= merged;
    end
  end

endmodule

`default_nettype wire

/* stripe_write_top.sv */
// Write striping front end top, splitter plus response arbiter and reorder
`timescale 1ns/1ps
`default_nettype none

module stripe_write_top
  import stripe_pkg::*;
#(
  parameter int N_CHAN     = 4,
  parameter int STRIPE_LOG = 8,
  parameter int ORD_DEPTH  = 16,
  parameter int RSP_DEPTH  = 8
) (
  input  logic               aclk,
  input  logic               aresetn,
  // Request port
  input  logic               s_req_valid,
  output logic               s_req_ready,
  input  addr_t              s_req_addr,
  input  len_t               s_req_len,
  // Sub-write port
  output logic               m_aw_valid,
  input  logic               m_aw_ready,
  output chan_t              m_aw_chan,
  output addr_t              m_aw_addr,
  output len_t               m_aw_len,
  // Channel response ports
  input  logic  [N_CHAN-1:0] ch_b_valid,
  output logic  [N_CHAN-1:0] ch_b_ready,
  input  resp_t [N_CHAN-1:0] ch_b_resp,
  // Final response port
  output logic               m_b_valid,
  input  logic               m_b_ready,
  output resp_t              m_b_resp
);

  // Order path
  logic  ord_valid;
  logic  ord_ready;
  chan_t ord_chan;
  logic  ord_last;
  // Return bus
  logic  rb_valid;
  logic  rb_ready;
  chan_t rb_chan;
  resp_t rb_resp;

  stripe_aw_split #(.N_CHAN(N_CHAN), .STRIPE_LOG(STRIPE_LOG)) i_split (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req_addr  (s_req_addr),
    .s_req_len   (s_req_len),
    .m_aw_valid  (m_aw_valid),
    .m_aw_ready  (m_aw_ready),
    .m_aw_chan   (m_aw_chan),
    .m_aw_addr   (m_aw_addr),
    .m_aw_len    (m_aw_len),
    .ord_valid   (ord_valid),
    .ord_ready   (ord_ready),
    .ord_chan    (ord_chan),
    .ord_last    (ord_last)
  );

  stripe_b_arbiter #(.N_CHAN(N_CHAN)) i_arb (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .ch_b_valid (ch_b_valid),
    .ch_b_ready (ch_b_ready),
    .ch_b_resp  (ch_b_resp),
    .rb_valid   (rb_valid),
    .rb_ready   (rb_ready),
    .rb_chan    (rb_chan),
    .rb_resp    (rb_resp)
  );

  stripe_b_reorder #(
    .N_CHAN    (N_CHAN),
    .ORD_DEPTH (ORD_DEPTH),
    .RSP_DEPTH (RSP_DEPTH)
  ) i_reorder (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .rb_valid  (rb_valid),
    .rb_ready  (rb_ready),
    .rb_chan   (rb_chan),
    .rb_resp   (rb_resp),
    .ord_valid (ord_valid),
    .ord_ready (ord_ready),
    .ord_chan  (ord_chan),
    .ord_last  (ord_last),
    .m_b_valid (m_b_valid),
    .m_b_ready (m_b_ready),
    .m_b_resp  (m_b_resp)
  );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// Testbench clock and synchronous reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Reset low for a fixed number of edges
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    aresetn <= 1'b1;
  end

endmodule

`default_nettype wire

/* stripe_checker.sv */
// Handshake stability and reset value assertions on the striping front end ports
`timescale 1ns/1ps
`default_nettype none

module stripe_checker
  import stripe_pkg::*;
(
  input logic  aclk,
  input logic  aresetn,
  input logic  m_aw_valid,
  input logic  m_aw_ready,
  input chan_t m_aw_chan,
  input addr_t m_aw_addr,
  input len_t  m_aw_len,
  input logic  m_b_valid,
  input logic  m_b_ready,
  input resp_t m_b_resp
);

  // Count of failed assertions
  int unsigned fail_count = 0;

  // Sub-write held until taken
  aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_aw_valid && !m_aw_ready) |=> (m_aw_valid && $stable(m_aw_chan)
      && $stable(m_aw_addr) && $stable(m_aw_len)))
    else begin
      fail_count++;
      $error("m_aw valid or payload changed before m_aw_ready");
    end

  // Final response held until taken
  b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_b_valid && !m_b_ready) |=> (m_b_valid && $stable(m_b_resp)))
    else begin
      fail_count++;
      $error("m_b valid or resp changed before m_b_ready");
    end

  // Both valids quiet right out of reset
  reset_quiet: assert property (@(posedge aclk)
    $rose(aresetn) |-> (!m_aw_valid && !m_b_valid))
    else begin
      fail_count++;
      $error("valid high in the first cycle after reset");
    end

endmodule

`default_nettype wire

/* tb_stripe_write.sv */
// Testbench for the write striping front end, with channel models and an in-order model
`timescale 1ns/1ps
`default_nettype none

module tb_stripe_write
  import stripe_pkg::*;
();

  localparam int          N_CHAN       = 4;
  localparam int          STRIPE_LOG   = 8;
  localparam int          STRIPE_BYTES = 1 << STRIPE_LOG;
  localparam int          N_REQ        = 60;
  localparam logic [31:0] SEED         = 32'ha96f592f;
  localparam int          RST_TMO      = 100;
  localparam int          REQ_TMO      = 3000;
  localparam int          DRAIN_TMO    = 20000;
  localparam int          HOLD_AFTER   = 20;
  localparam int          HOLD_CYC     = 400;
  localparam int          HOLD_LATE    = 100;

  logic                aclk;
  logic                aresetn;
  logic                s_req_valid = 1'b0;
  logic                s_req_ready;
  addr_t               s_req_addr  = '0;
  len_t                s_req_len   = '0;
  logic                m_aw_valid;
  logic                m_aw_ready  = 1'b0;
  chan_t               m_aw_chan;
  addr_t               m_aw_addr;
  len_t                m_aw_len;
  logic  [N_CHAN-1:0]  ch_b_valid  = '0;
  logic  [N_CHAN-1:0]  ch_b_ready;
  resp_t [N_CHAN-1:0]  ch_b_resp   = '0;
  logic                m_b_valid;
  logic                m_b_ready   = 1'b0;
  resp_t               m_b_resp;

  // Expected sub-writes in issue order, tagged with their request
  addr_t       exp_aw_addr[$];
  len_t        exp_aw_len[$];
  chan_t       exp_aw_chan[$];
  int          exp_aw_req[$];
  // Per channel, request index of each piece still unanswered
  int          ch_pend[N_CHAN][$];
  int          ch_wait[N_CHAN];
  // Folded response and open pieces per request
  resp_t       exp_resp[N_REQ];
  int          pieces_left[N_REQ];
  int          req_sent = 0;
  int          aw_seen  = 0;
  int          b_seen   = 0;
  int          err_count = 0;
  int          tmo_count = 0;
  int unsigned assert_fails;
  logic        hold_b = 1'b0;
  logic [31:0] req_rng = SEED;
  logic [31:0] mon_rng = SEED ^ 32'h5bd1e995;

  tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(5)) i_clkgen (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  stripe_write_top #(
    .N_CHAN     (N_CHAN),
    .STRIPE_LOG (STRIPE_LOG),
    .ORD_DEPTH  (16),
    .RSP_DEPTH  (8)
  ) i_dut (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req_addr  (s_req_addr),
    .s_req_len   (s_req_len),
    .m_aw_valid  (m_aw_valid),
    .m_aw_ready  (m_aw_ready),
    .m_aw_chan   (m_aw_chan),
    .m_aw_addr   (m_aw_addr),
    .m_aw_len    (m_aw_len),
    .ch_b_valid  (ch_b_valid),
    .ch_b_ready  (ch_b_ready),
    .ch_b_resp   (ch_b_resp),
    .m_b_valid   (m_b_valid),
    .m_b_ready   (m_b_ready),
    .m_b_resp    (m_b_resp)
  );

  bind stripe_write_top stripe_checker i_checker (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_aw_chan  (m_aw_chan),
    .m_aw_addr  (m_aw_addr),
    .m_aw_len   (m_aw_len),
    .m_b_valid  (m_b_valid),
    .m_b_ready  (m_b_ready),
    .m_b_resp   (m_b_resp)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits, the low ones cycle too fast
  function automatic logic [15:0] req_draw();
    req_rng = lcg_next(req_rng);
    return req_rng[31:16];
  endfunction

  function automatic logic [15:0] mon_draw();
    mon_rng = lcg_next(mon_rng);
    return mon_rng[31:16];
  endfunction

  // Higher code is the worse one
  function automatic resp_t worse_of(input resp_t a, input resp_t b);
    if (b > a) begin
      return b;
    end
    return a;
  endfunction

  // Stripe cut of one request into expected pieces
  task automatic cut_request(input int idx, input addr_t addr, input len_t len);
    addr_t cur;
    int    rem;
    int    room;
    int    piece;
    cur = addr;
    rem = int'(len);
    while (rem > 0) begin
      room  = STRIPE_BYTES - int'(cur % STRIPE_BYTES);
      piece = (rem < room) ? rem : room;
      exp_aw_addr.push_back(cur);
      exp_aw_len.push_back(len_t'(piece));
      exp_aw_chan.push_back(chan_t'((cur / STRIPE_BYTES) % N_CHAN));
      exp_aw_req.push_back(idx);
      pieces_left[idx]++;
      cur = cur + addr_t'(piece);
      rem = rem - piece;
    end
  endtask

  task automatic send_requests();
    logic [15:0] hi;
    logic [15:0] lo;
    len_t        len;
    int          wait_cyc;
    logic        taken;
    logic        stuck;
    stuck = 1'b0;
    for (int i = 0; i < N_REQ && !stuck; i++) begin
      hi  = req_draw();
      lo  = req_draw();
      len = len_t'(1 + int'(req_draw()) % 700);
      cut_request(i, {hi, lo}, len);
      s_req_valid <= 1'b1;
      s_req_addr  <= {hi, lo};
      s_req_len   <= len;
      taken    = 1'b0;
      wait_cyc = 0;
      while (!taken && wait_cyc < REQ_TMO) begin
        @(posedge aclk);
        if (s_req_ready) begin
          taken = 1'b1;
        end else begin
          wait_cyc++;
        end
      end
      if (taken) begin
        req_sent <= req_sent + 1;
      end else begin
        stuck = 1'b1;
        tmo_count++;
        $display("Timeout: request %0d was never accepted", i);
      end
    end
    s_req_valid <= 1'b0;
  endtask

  // Long m_b_ready stall once traffic is running
  task automatic stall_responses();
    int wait_cyc;
    int aw_mark;
    wait_cyc = 0;
    while (req_sent < HOLD_AFTER && wait_cyc < REQ_TMO) begin
      @(posedge aclk);
      wait_cyc++;
    end
    if (req_sent < HOLD_AFTER) begin
      tmo_count++;
      $display("Timeout: traffic never reached the response stall point");
    end else begin
      hold_b <= 1'b1;
      repeat (HOLD_CYC - HOLD_LATE) @(posedge aclk);
      aw_mark = aw_seen;
      repeat (HOLD_LATE) @(posedge aclk);
      hold_b <= 1'b0;
      // Queues should be full by now
      if (aw_seen != aw_mark) begin
        err_count++;
        $display("Sub-writes kept flowing with the response port held off");
      end
    end
  endtask

  // Channel models, sub-write check and response check
  always @(posedge aclk) begin
    int          r;
    int          c_idx;
    logic [15:0] v;
    addr_t       ea;
    len_t        el;
    chan_t       ec;
    if (aresetn) begin
      for (int c = 0; c < N_CHAN; c++) begin
        if (ch_b_valid[c] && ch_b_ready[c]) begin
          r = ch_pend[c].pop_front();
          exp_resp[r] = worse_of(exp_resp[r], ch_b_resp[c]);
          pieces_left[r]--;
          ch_b_valid[c] <= 1'b0;
          ch_wait[c] = int'(mon_draw() % 16);
        end else if (!ch_b_valid[c] && ch_pend[c].size() > 0) begin
          if (ch_wait[c] > 0) begin
            ch_wait[c]--;
          end else begin
            // Mostly OKAY, now and then an error code
            v = mon_draw();
            ch_b_valid[c] <= 1'b1;
            ch_b_resp[c]  <= (v[3:0] < 12) ? RESP_OKAY :
                             (v[3:0] < 14) ? RESP_SLVERR : RESP_DECERR;
          end
        end
      end
      if (m_aw_valid && m_aw_ready) begin
        aw_seen <= aw_seen + 1;
        if (exp_aw_addr.size() == 0) begin
          err_count++;
          $display("Unexpected sub-write at %0t with no request left to cut", $time);
        end else begin
          ea = exp_aw_addr.pop_front();
          el = exp_aw_len.pop_front();
          ec = exp_aw_chan.pop_front();
          r  = exp_aw_req.pop_front();
          if (m_aw_addr != ea) begin
            err_count++;
            $display("ERR %0t m_aw_addr expected %h got %h", $time, ea, m_aw_addr);
          end
          if (m_aw_len != el) begin
            err_count++;
            $display("ERR %0t m_aw_len expected %0d got %0d", $time, el, m_aw_len);
          end
          if (m_aw_chan != ec) begin
            err_count++;
            $display("ERR %0t m_aw_chan expected %0d got %0d", $time, ec, m_aw_chan);
          end
          c_idx = int'(m_aw_chan) % N_CHAN;
          ch_pend[c_idx].push_back(r);
        end
      end
      if (m_b_valid && m_b_ready) begin
        b_seen <= b_seen + 1;
        if (b_seen >= req_sent) begin
          err_count++;
          $display("Extra m_b response at %0t beyond the accepted requests", $time);
        end else begin
          if (pieces_left[b_seen] != 0) begin
            err_count++;
            $display("Response %0d came before all its pieces were answered", b_seen);
          end
          if (m_b_resp != exp_resp[b_seen]) begin
            err_count++;
            $display("ERR %0t m_b_resp expected %0d got %0d", $time,
                     exp_resp[b_seen], m_b_resp);
          end
        end
      end
      v = mon_draw();
      m_aw_ready <= (v[1:0] != 2'b00);
      m_b_ready  <= hold_b ? 1'b0 : v[8];
    end
  end

  initial begin
    int wait_cyc;
    for (int i = 0; i < N_REQ; i++) begin
      exp_resp[i]    = RESP_OKAY;
      pieces_left[i] = 0;
    end
    for (int c = 0; c < N_CHAN; c++) begin
      ch_wait[c] = 0;
    end
    wait_cyc = 0;
    while (aresetn !== 1'b1 && wait_cyc < RST_TMO) begin
      @(posedge aclk);
      wait_cyc++;
    end
    if (aresetn !== 1'b1) begin
      tmo_count++;
      $display("Timeout: reset never released");
    end else begin
      fork
        send_requests();
        stall_responses();
      join
      wait_cyc = 0;
      while (b_seen < N_REQ && wait_cyc < DRAIN_TMO) begin
        @(posedge aclk);
        wait_cyc++;
      end
      if (b_seen < N_REQ) begin
        tmo_count++;
        $display("Timeout: only %0d of %0d responses arrived", b_seen, N_REQ);
      end
      // Quiet tail to catch stray responses
      repeat (50) @(posedge aclk);
      if (exp_aw_addr.size() != 0) begin
        err_count++;
        $display("%0d expected sub-writes were never issued", exp_aw_addr.size());
      end
    end
    assert_fails = i_dut.i_checker.fail_count;
    $display("Summary: %0d sub-writes, %0d responses, %0d errors, %0d timeouts, %0d %s",
             aw_seen, b_seen, err_count, tmo_count, assert_fails, "assertion failures");
    if (err_count == 0 && tmo_count == 0 && assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* stripe_write_top.f */
stripe_pkg.sv
stripe_fifo.sv
stripe_aw_split.sv
stripe_b_arbiter.sv
stripe_b_reorder.sv
stripe_write_top.sv
tb_clkgen.sv
stripe_checker.sv
tb_stripe_write.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_stripe_write
FILELIST  := stripe_write_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SIM_ARGS  := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(SIM_LOG) 2>&1 || true
	cat $(SIM_LOG)
	@if grep -q "Simulation finished: FAIL" $(SIM_LOG); then exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(SIM_LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
